//--- filelist.f
+incdir+hdl
hdl/ntt_pkg.sv
hdl/ntt_mem_if.sv
hdl/ntt_host_adapter.sv
hdl/ntt_coef_mem.sv
hdl/ntt_seq_fsm.sv
hdl/ntt_row_counter.sv
hdl/ntt_lane_alu.sv
hdl/ntt_top.sv
tests/ntt_tb.sv

//--- Makefile
# Verilator build and run of the NTT coprocessor testbench

LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module ntt_tb

run: build
	./obj_dir/Vntt_tb | tee $(LOG)
	grep -qx "sim passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module ntt_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

//--- tests/ntt_tb.sv
//====================================================================
// Testbench for the NTT pointwise coprocessor slice
// Loads A and B, runs each mode and checks C, timing and errors
//====================================================================
`timescale 1ns/1ns
`default_nettype none
`include "ntt_defs.svh"

module ntt_tb import ntt_pkg::*; ();

localparam int     NUM_TESTS   = 5;
localparam int     RUN_CYCLES  = 3 * `NTT_ROWS + 1;   // Enable write to done pulse
localparam longint WATCHDOG_NS = 40 * NUM_TESTS * (3 * `NTT_ROWS + 200) * 8;

logic                        clk;
logic                        rst_n_i;
logic                        dv_i;
logic                        write_i;
logic [`NTT_HOST_ADDR_W-1:0] addr_i;
logic [`NTT_HOST_DATA_W-1:0] wdata_i;
logic [`NTT_HOST_DATA_W-1:0] rdata_o;
logic                        hold_o;
logic                        err_o;
logic                        busy_o;
logic                        done_o;
logic                        start_seen;

logic [`NTT_COEF_W-1:0] a_ref [`NTT_N];   // Expected memory contents
logic [`NTT_COEF_W-1:0] b_ref [`NTT_N];
logic [`NTT_COEF_W-1:0] c_ref [`NTT_N];
logic [15:0]            lfsr = 16'd3666;
int errors       = 0;
int err_mark     = 0;
int test_num     = 0;
int tests_failed = 0;
int cyc          = 0;
int start_cyc    = 0;
int done_cyc     = 0;
int done_cnt     = 0;

ntt_top dut (.*);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

// Watchdog
initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("sim failed");
    $finish;
end

//====================================================================
// Stimulus helpers and reference model
//====================================================================
function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11
    lfsr = {lfsr[14:0], fb};
    return fb;
endfunction

function automatic logic [`NTT_COEF_W-1:0] rand_coef();
    logic [`NTT_COEF_W-1:0] v;
    v = '0;
    for (int i = 0; i < `NTT_COEF_W; i++)
        v = {v[`NTT_COEF_W-2:0], lfsr_bit()};
    return `NTT_COEF_W'(v % `NTT_Q);                       // Keep below q
endfunction

function automatic logic [`NTT_COEF_W-1:0] expected_lane(input mode_e m, input logic acc,
        input logic [`NTT_COEF_W-1:0] a, input logic [`NTT_COEF_W-1:0] b,
        input logic [`NTT_COEF_W-1:0] c);
    longint q;
    longint r;
    q = `NTT_Q;
    case (m)
        MODE_ADD: r = (longint'(a) + longint'(b)) % q;
        MODE_SUB: r = (longint'(a) - longint'(b) + q) % q;
        default:  r = (longint'(a) * longint'(b)) % q;
    endcase
    if (acc)
        r = (r + longint'(c)) % q;                          // Old C folded in
    return `NTT_COEF_W'(r);
endfunction

task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
        $display("ERR t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
        errors++;
    end
endtask

task automatic drive_write(input int addr, input logic [31:0] data, output logic err);
    @(posedge clk);
    dv_i    <= 1'b1;
    write_i <= 1'b1;
    addr_i  <= `NTT_HOST_ADDR_W'(addr);
    wdata_i <= data;
    @(negedge clk);
    while (hold_o)
        @(negedge clk);
    err = err_o;
    @(posedge clk);                                         // Write lands here
    dv_i    <= 1'b0;
    write_i <= 1'b0;
endtask

task automatic drive_read(input int addr, output logic [31:0] data, output int holds,
        output logic err);
    @(posedge clk);
    dv_i    <= 1'b1;
    write_i <= 1'b0;
    addr_i  <= `NTT_HOST_ADDR_W'(addr);
    holds = 0;
    @(negedge clk);
    while (hold_o) begin
        holds++;
        @(negedge clk);
    end
    data = rdata_o;
    err  = err_o;
    @(posedge clk);
    dv_i <= 1'b0;
endtask

task automatic run_engine(input mode_e mode, input logic accumulate);
    logic err;
    drive_write(`NTT_ADDR_CTRL, 32'({accumulate, mode}), err);
    compare("err_o", 0, 32'(err));
    drive_write(`NTT_ADDR_EN, 32'd1, err);
    @(negedge clk);
    while (!done_o)
        @(negedge clk);
endtask

task automatic check_c();
    logic [31:0] data;
    int          holds;
    logic        err;
    for (int i = 0; i < `NTT_N; i++) begin
        drive_read(`NTT_BASE_C + i, data, holds, err);
        compare($sformatf("c[%0d]", i), 32'(c_ref[i]), data);
    end
endtask

task automatic report_test(input string name);
    test_num++;
    if (errors == err_mark) begin
        $display("test %0d %s: ok", test_num, name);
    end else begin
        tests_failed++;
        $display("test %0d %s: %0d errors", test_num, name, errors - err_mark);
    end
    err_mark = errors;
endtask

//====================================================================
// Bus and engine checks
//====================================================================
assign start_seen = dv_i && write_i && !hold_o && !err_o &&
                    addr_i == `NTT_ADDR_EN && wdata_i[0];

always @(posedge clk) begin
    cyc <= cyc + 1;
    if (start_seen)
        start_cyc <= cyc;
    if (done_o) begin
        done_cnt <= done_cnt + 1;
        done_cyc <= cyc;
    end
end

assert property (@(posedge clk) disable iff (!rst_n_i) start_seen |=> busy_o) else begin
    $display("engine did not go busy after a start at t=%0t", $time);
    errors++;
end
assert property (@(posedge clk) disable iff (!rst_n_i) done_o |=> !done_o) else begin
    $display("done_o stayed high for more than one cycle at t=%0t", $time);
    errors++;
end
assert property (@(posedge clk) disable iff (!rst_n_i) (busy_o && !done_o) |=> busy_o)
else begin
    $display("busy_o dropped before the done cycle at t=%0t", $time);
    errors++;
end
assert property (@(posedge clk) disable iff (!rst_n_i) err_o |-> !hold_o ##1 !err_o)
else begin
    $display("error response was held or lasted more than one cycle at t=%0t", $time);
    errors++;
end
// Only a status read gets through a busy engine
assert property (@(posedge clk) disable iff (!rst_n_i)
    (dv_i && busy_o && !(!write_i && addr_i == `NTT_ADDR_STATUS)) |-> hold_o) else begin
    $display("host access was not held during a run at t=%0t", $time);
    errors++;
end

//====================================================================
// Test sequence
//====================================================================
initial begin
    logic [31:0] data;
    int          holds;
    logic        err;
    int          d0;
    rst_n_i = 1'b0;
    dv_i    = 1'b0;
    write_i = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    repeat (16) @(posedge clk);
    rst_n_i <= 1'b1;

    for (int i = 0; i < `NTT_N; i++) begin
        a_ref[i] = rand_coef();
        b_ref[i] = rand_coef();
        c_ref[i] = '0;
        drive_write(`NTT_BASE_A + i, 32'(a_ref[i]), err);
        drive_write(`NTT_BASE_B + i, 32'(b_ref[i]), err);
    end
    for (int i = 0; i < `NTT_N; i++) begin
        drive_read(`NTT_BASE_A + i, data, holds, err);
        compare($sformatf("a[%0d]", i), 32'(a_ref[i]), data);
        compare("hold_o cycles", 1, holds);
        drive_read(`NTT_BASE_B + i, data, holds, err);
        compare($sformatf("b[%0d]", i), 32'(b_ref[i]), data);
        compare("hold_o cycles", 1, holds);
    end
    report_test("load and read back");

    for (int m = 0; m < 3; m++) begin                       // ADD, SUB, MUL
        run_engine(mode_e'(m), 1'b0);
        for (int i = 0; i < `NTT_N; i++)
            c_ref[i] = expected_lane(mode_e'(m), 1'b0, a_ref[i], b_ref[i], c_ref[i]);
        check_c();
    end
    report_test("pointwise modes");

    run_engine(MODE_ADD, 1'b1);                             // C still holds a*b
    for (int i = 0; i < `NTT_N; i++)
        c_ref[i] = expected_lane(MODE_ADD, 1'b1, a_ref[i], b_ref[i], c_ref[i]);
    check_c();
    report_test("accumulate");

    d0 = done_cnt;
    drive_write(`NTT_ADDR_CTRL, 32'(MODE_ADD), err);
    drive_write(`NTT_ADDR_EN, 32'd1, err);
    drive_read(`NTT_ADDR_STATUS, data, holds, err);         // Busy, done cleared
    compare("status", 32'h1, data);
    drive_read(`NTT_BASE_C, data, holds, err);              // Parked until done
    for (int i = 0; i < `NTT_N; i++)
        c_ref[i] = expected_lane(MODE_ADD, 1'b0, a_ref[i], b_ref[i], c_ref[i]);
    compare("c[0]", 32'(c_ref[0]), data);
    compare("done_o pulses", d0 + 1, done_cnt);
    compare("done_o delay", RUN_CYCLES, done_cyc - start_cyc);
    drive_read(`NTT_ADDR_STATUS, data, holds, err);         // Idle, done kept
    compare("status", 32'h2, data);
    report_test("run timing");

    drive_read(200, data, holds, err);
    compare("err_o", 1, 32'(err));
    drive_write(255, 32'd0, err);
    compare("err_o", 1, 32'(err));
    drive_write(`NTT_ADDR_CTRL, 32'(MODE_MUL), err);
    drive_write(`NTT_ADDR_CTRL, 32'd5, err);                // Reserved mode
    compare("err_o", 1, 32'(err));
    drive_read(`NTT_ADDR_CTRL, data, holds, err);
    compare("ctrl", 32'(MODE_MUL), data);
    report_test("error responses");

    $display("tests %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
    if (errors == 0)
        $display("sim passed");
    else
        $display("sim failed");
    $finish;
end

endmodule

`default_nettype wire

//--- hdl/ntt_top.sv
//====================================================================
// NTT pointwise coprocessor slice, host bus and status pins
//====================================================================
`timescale 1ns/1ns
`default_nettype none
`include "ntt_defs.svh"

module ntt_top import ntt_pkg::*; (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         dv_i,
    input  wire                         write_i,
    input  wire [`NTT_HOST_ADDR_W-1:0]  addr_i,
    input  wire [`NTT_HOST_DATA_W-1:0]  wdata_i,
    output logic [`NTT_HOST_DATA_W-1:0] rdata_o,
    output logic                        hold_o,
    output logic                        err_o,
    output logic                        busy_o,
    output logic                        done_o
);

logic                          start;
mode_e                         mode;
logic                          accumulate;
logic [$clog2(`NTT_ROWS)-1:0]  row;
logic                          last_row;
logic                          row_clr;
logic                          row_step;
logic                          alu_load;

ntt_eng_mem_if  eng_if ();
ntt_host_mem_if host_if ();

ntt_host_adapter u_adapter (
    .clk, .rst_n_i, .dv_i, .write_i, .addr_i, .wdata_i,
    .rdata_o, .hold_o, .err_o,
    .busy_i       (busy_o),
    .done_i       (done_o),
    .start_o      (start),
    .mode_o       (mode),
    .accumulate_o (accumulate),
    .host_mem     (host_if.host)
);

ntt_coef_mem u_mem (
    .clk,
    .eng  (eng_if.mem),
    .host (host_if.mem)
);

ntt_seq_fsm u_fsm (
    .clk, .rst_n_i,
    .start_i    (start),
    .last_row_i (last_row),
    .row_i      (row),
    .row_clr_o  (row_clr),
    .row_step_o (row_step),
    .alu_load_o (alu_load),
    .busy_o, .done_o,
    .eng        (eng_if.engine)
);

ntt_row_counter u_row (
    .clk, .rst_n_i,
    .clr_i  (row_clr),
    .step_i (row_step),
    .row_o  (row),
    .last_o (last_row)
);

// Port A carries A, then C one cycle later
ntt_lane_alu u_alu (
    .clk, .rst_n_i,
    .load_i       (alu_load),
    .mode_i       (mode),
    .accumulate_i (accumulate),
    .a_i          (eng_if.rd_data_a),
    .b_i          (eng_if.rd_data_b),
    .c_i          (eng_if.rd_data_a),
    .result_o     (eng_if.wr_data)
);

endmodule

`default_nettype wire

//--- hdl/ntt_lane_alu.sv
//====================================================================
// Four-lane mod-q ALU, add, subtract or multiply with accumulate
//====================================================================
`timescale 1ns/1ns
`default_nettype none
`include "ntt_defs.svh"

module ntt_lane_alu import ntt_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   load_i,
    input  mode_e                 mode_i,
    input  wire                   accumulate_i,
    input  wire [`NTT_ROW_W-1:0]  a_i,
    input  wire [`NTT_ROW_W-1:0]  b_i,
    input  wire [`NTT_ROW_W-1:0]  c_i,
    output logic [`NTT_ROW_W-1:0] result_o
);

logic [`NTT_ROW_W-1:0] a_q;
logic [`NTT_ROW_W-1:0] b_q;

// One conditional subtract, input below 2q
function automatic logic [`NTT_COEF_W-1:0] red_once(input logic [`NTT_COEF_W:0] x);
    return (x >= `NTT_Q) ? `NTT_COEF_W'(x - `NTT_Q) : `NTT_COEF_W'(x);
endfunction

function automatic logic lanes_below_q(input logic [`NTT_ROW_W-1:0] row);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < `NTT_LANES; i++)
        ok = ok && (row[i*`NTT_COEF_W +: `NTT_COEF_W] < `NTT_Q);
    return ok;
endfunction

always_ff @(posedge clk) begin
    if (load_i) begin
        a_q <= a_i;
        b_q <= b_i;
    end
end

always_comb begin : lane_calc
    logic [`NTT_COEF_W-1:0]   a;
    logic [`NTT_COEF_W-1:0]   b;
    logic [`NTT_COEF_W-1:0]   r;
    logic [2*`NTT_COEF_W-1:0] prod;
    for (int i = 0; i < `NTT_LANES; i++) begin
        a    = a_q[i*`NTT_COEF_W +: `NTT_COEF_W];
        b    = b_q[i*`NTT_COEF_W +: `NTT_COEF_W];
        prod = a * b;
        unique case (mode_i)
            MODE_ADD: r = red_once({1'b0, a} + {1'b0, b});
            MODE_SUB: r = red_once({1'b0, a} + (`NTT_COEF_W+1)'(`NTT_Q) - {1'b0, b});
            MODE_MUL: r = `NTT_COEF_W'(prod % `NTT_Q);
            default:  r = '0;
        endcase
        if (accumulate_i)    // Old C lane comes in with the write cycle
            r = red_once({1'b0, r} + {1'b0, c_i[i*`NTT_COEF_W +: `NTT_COEF_W]});
        result_o[i*`NTT_COEF_W +: `NTT_COEF_W] = r;
    end
end

// Host keeps stored coefficients reduced
assert property (@(posedge clk) disable iff (!rst_n_i)
    load_i |-> lanes_below_q(a_i) && lanes_below_q(b_i));
assert property (@(posedge clk) disable iff (!rst_n_i)
    ($past(load_i) && accumulate_i) |-> lanes_below_q(c_i));

endmodule

`default_nettype wire

//--- hdl/ntt_row_counter.sv
//====================================================================
// Row index counter with last-row flag
//====================================================================
`timescale 1ns/1ns
`default_nettype none
`include "ntt_defs.svh"

module ntt_row_counter (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         clr_i,
    input  wire                         step_i,
    output logic [$clog2(`NTT_ROWS)-1:0] row_o,
    output logic                        last_o
);

always_ff @(posedge clk) begin
    if (!rst_n_i || clr_i)
        row_o <= '0;
    else if (step_i)
        row_o <= row_o + 1'b1;
end

assign last_o = row_o == ($clog2(`NTT_ROWS))'(`NTT_ROWS - 1);

// Sequencer stops stepping on the last row
assert property (@(posedge clk) disable iff (!rst_n_i)
    step_i |-> !last_o);

endmodule

`default_nettype wire

//--- hdl/ntt_seq_fsm.sv
//====================================================================
// Engine sequencer, three cycles per row then one done cycle
//====================================================================
`timescale 1ns/1ns
`default_nettype none
`include "ntt_defs.svh"

module ntt_seq_fsm import ntt_pkg::*; (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire                           start_i,
    input  wire                           last_row_i,
    input  wire [$clog2(`NTT_ROWS)-1:0]   row_i,
    output logic                          row_clr_o,
    output logic                          row_step_o,
    output logic                          alu_load_o,
    output logic                          busy_o,
    output logic                          done_o,
    ntt_eng_mem_if.engine                 eng
);

seq_state_e                 state_q;
seq_state_e                 state_d;
logic [`NTT_ROW_ADDR_W-1:0] row_ext;

assign row_ext = `NTT_ROW_ADDR_W'(row_i);

always_comb begin
    state_d = state_q;
    unique case (state_q)
        ST_IDLE:  if (start_i) state_d = ST_RD_AB;
        ST_RD_AB: state_d = ST_RD_C;
        ST_RD_C:  state_d = ST_WR;
        ST_WR:    state_d = last_row_i ? ST_DONE : ST_RD_AB;
        ST_DONE:  state_d = ST_IDLE;
        default:  state_d = ST_IDLE;
    endcase
end

always_ff @(posedge clk) begin
    if (!rst_n_i)
        state_q <= ST_IDLE;
    else
        state_q <= state_d;
end

// Port A reads A then C, port B reads B
assign eng.rd_en     = (state_q == ST_RD_AB) || (state_q == ST_RD_C);
assign eng.rd_addr_a = (state_q == ST_RD_C) ? row_ext + `NTT_ROW_ADDR_W'(2*`NTT_ROWS)
                                            : row_ext;
assign eng.rd_addr_b = row_ext + `NTT_ROW_ADDR_W'(`NTT_ROWS);
assign eng.wr_en     = state_q == ST_WR;
assign eng.wr_addr   = row_ext + `NTT_ROW_ADDR_W'(2*`NTT_ROWS);

assign row_clr_o  = (state_q == ST_IDLE) && start_i;
assign row_step_o = (state_q == ST_WR) && !last_row_i;
assign alu_load_o = state_q == ST_RD_C;   // A and B rows arrive here
assign busy_o     = state_q != ST_IDLE;
assign done_o     = state_q == ST_DONE;

// Adapter must hold every enable write while a run is in flight
assert property (@(posedge clk) disable iff (!rst_n_i)
    start_i |-> state_q == ST_IDLE);

endmodule

`default_nettype wire

//--- hdl/ntt_coef_mem.sv
//====================================================================
// Coefficient row memory, polys A, B and C at 16 rows each
//====================================================================
`timescale 1ns/1ns
`default_nettype none
`include "ntt_defs.svh"

module ntt_coef_mem (
    input wire          clk,
    ntt_eng_mem_if.mem  eng,
    ntt_host_mem_if.mem host
);

// Rows 0..15 A, 16..31 B, 32..47 C
logic [`NTT_ROW_W-1:0] rows [0:3*`NTT_ROWS-1];

always_ff @(posedge clk) begin
    // Engine side, two row reads and one row write
    if (eng.rd_en) begin
        eng.rd_data_a <= rows[eng.rd_addr_a];
        eng.rd_data_b <= rows[eng.rd_addr_b];
    end
    if (eng.wr_en)
        rows[eng.wr_addr] <= eng.wr_data;

    // Host side, one lane per access
    if (host.en) begin
        if (host.we)
            rows[host.row][host.lane*`NTT_COEF_W +: `NTT_COEF_W] <= host.wdata;
        else
            host.rdata <= rows[host.row][host.lane*`NTT_COEF_W +: `NTT_COEF_W];
    end
end

// Host is parked by the adapter during a run
assert property (@(posedge clk) !(host.en && eng.wr_en));

endmodule

`default_nettype wire

//--- hdl/ntt_host_adapter.sv
//====================================================================
// Host bus adapter, decodes word accesses into coefficient lanes,
// holds the control word and starts the engine
//====================================================================
`timescale 1ns/1ns
`default_nettype none
`include "ntt_defs.svh"

module ntt_host_adapter import ntt_pkg::*; (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         dv_i,
    input  wire                         write_i,
    input  wire [`NTT_HOST_ADDR_W-1:0]  addr_i,
    input  wire [`NTT_HOST_DATA_W-1:0]  wdata_i,
    output logic [`NTT_HOST_DATA_W-1:0] rdata_o,
    output logic                        hold_o,
    output logic                        err_o,
    input  wire                         busy_i,
    input  wire                         done_i,
    output logic                        start_o,
    output mode_e                       mode_o,
    output logic                        accumulate_o,
    ntt_host_mem_if.host                host_mem
);

logic                        is_coef;
logic                        is_ctrl;
logic                        is_en;
logic                        is_status;
logic                        bad;           // Bad address or reserved mode
logic                        busy_blk;      // Access parked until engine done
logic                        acc;
logic                        rd_first;
logic                        wr_ok;
logic [1:0]                  poly_idx;
logic [`NTT_HOST_ADDR_W-1:0] poly_base;
logic [`NTT_HOST_ADDR_W-1:0] word_off;
logic                        rd_pend_q;     // Second read cycle
logic                        rd_src_mem_q;
logic [`NTT_HOST_DATA_W-1:0] reg_rdata_q;
logic                        done_sticky_q;
ntt_ctrl_t                   ctrl_q;

//====================================================================
// Address decode
//====================================================================
assign is_coef   = addr_i < (`NTT_BASE_C + `NTT_N);
assign is_ctrl   = addr_i == `NTT_ADDR_CTRL;
assign is_en     = addr_i == `NTT_ADDR_EN;
assign is_status = addr_i == `NTT_ADDR_STATUS;
assign bad       = (addr_i > `NTT_ADDR_STATUS) ||
                   (write_i && is_ctrl && (wdata_i[2:0] > MODE_MUL));

always_comb begin
    if (addr_i >= `NTT_BASE_C) begin
        poly_idx  = 2'd2;
        poly_base = `NTT_HOST_ADDR_W'(`NTT_BASE_C);
    end else if (addr_i >= `NTT_BASE_B) begin
        poly_idx  = 2'd1;
        poly_base = `NTT_HOST_ADDR_W'(`NTT_BASE_B);
    end else begin
        poly_idx  = 2'd0;
        poly_base = `NTT_HOST_ADDR_W'(`NTT_BASE_A);
    end
end
assign word_off = addr_i - poly_base;      // Coefficient index in poly

//====================================================================
// Handshake
//====================================================================
assign busy_blk = busy_i && !(is_status && !write_i);   // Status readable
assign acc      = dv_i && !busy_blk;
assign err_o    = acc && bad;
assign rd_first = acc && !bad && !write_i && !rd_pend_q;
assign wr_ok    = acc && !bad && write_i;
assign hold_o   = (dv_i && busy_blk) || rd_first;
assign start_o  = wr_ok && is_en && wdata_i[0];        // Not stored

// Memory side, one lane per host word
assign host_mem.en    = (rd_first || wr_ok) && is_coef;
assign host_mem.we    = write_i;
assign host_mem.row   = `NTT_ROW_ADDR_W'(poly_idx * `NTT_ROWS + word_off / `NTT_LANES);
assign host_mem.lane  = word_off[1:0];
assign host_mem.wdata = wdata_i[`NTT_COEF_W-1:0];      // Upper bits dropped

always_ff @(posedge clk) begin
    if (!rst_n_i) begin
        rd_pend_q     <= 1'b0;
        rd_src_mem_q  <= 1'b0;
        reg_rdata_q   <= '0;
        done_sticky_q <= 1'b0;
        ctrl_q        <= '{accumulate: 1'b0, mode: MODE_ADD};
    end else begin
        rd_pend_q <= rd_first;
        if (rd_first) begin
            rd_src_mem_q <= is_coef;
            reg_rdata_q  <= is_ctrl ? `NTT_HOST_DATA_W'(ctrl_q)
                                    : `NTT_HOST_DATA_W'({done_sticky_q, busy_i});
        end
        if (wr_ok && is_ctrl)
            ctrl_q <= ntt_ctrl_t'(wdata_i[3:0]);
        if (start_o)
            done_sticky_q <= 1'b0;             // Next run clears it
        else if (done_i)
            done_sticky_q <= 1'b1;
    end
end

assign rdata_o      = rd_src_mem_q ? `NTT_HOST_DATA_W'(host_mem.rdata) : reg_rdata_q;
assign mode_o       = ctrl_q.mode;
assign accumulate_o = ctrl_q.accumulate;

// Read data only moves when a new read is issued
assert property (@(posedge clk) disable iff (!rst_n_i)
    (!hold_o && !dv_i) |-> $stable(rdata_o));

endmodule

`default_nettype wire

//--- hdl/ntt_mem_if.sv
//====================================================================
// Coefficient memory paths, engine row port and host lane port
//====================================================================
`timescale 1ns/1ns
`default_nettype none
`include "ntt_defs.svh"

interface ntt_eng_mem_if;
    logic                       rd_en;
    logic [`NTT_ROW_ADDR_W-1:0] rd_addr_a;
    logic [`NTT_ROW_ADDR_W-1:0] rd_addr_b;
    logic [`NTT_ROW_W-1:0]      rd_data_a;  // One cycle after rd_en
    logic [`NTT_ROW_W-1:0]      rd_data_b;
    logic                       wr_en;
    logic [`NTT_ROW_ADDR_W-1:0] wr_addr;
    logic [`NTT_ROW_W-1:0]      wr_data;    // Driven by the lane ALU

    modport engine (output rd_en, rd_addr_a, rd_addr_b, wr_en, wr_addr,
                    input  rd_data_a, rd_data_b);
    modport mem    (input  rd_en, rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
                    output rd_data_a, rd_data_b);
endinterface

interface ntt_host_mem_if;
    logic                       en;
    logic                       we;
    logic [`NTT_ROW_ADDR_W-1:0] row;
    logic [1:0]                 lane;
    logic [`NTT_COEF_W-1:0]     wdata;
    logic [`NTT_COEF_W-1:0]     rdata;      // Registered lane read

    modport host (output en, we, row, lane, wdata, input rdata);
    modport mem  (input en, we, row, lane, wdata, output rdata);
endinterface

`default_nettype wire

//--- hdl/ntt_pkg.sv
//====================================================================
// NTT coprocessor types
// Modes, sequencer states and the control word layout
//====================================================================
`default_nettype none

package ntt_pkg;

    // Lane operation, 3..7 reserved
    typedef enum logic [2:0] {
        MODE_ADD = 3'd0,
        MODE_SUB = 3'd1,
        MODE_MUL = 3'd2
    } mode_e;

    // One pass per row is RD_AB, RD_C, WR
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_AB,
        ST_RD_C,
        ST_WR,
        ST_DONE
    } seq_state_e;

    // Control register, bit 3 accumulate and bits 2..0 mode
    typedef struct packed {
        logic  accumulate;
        mode_e mode;
    } ntt_ctrl_t;

endpackage

`default_nettype wire

//--- hdl/ntt_defs.svh
//====================================================================
// NTT coprocessor sizes, modulus and host word address map
//====================================================================
`ifndef NTT_DEFS_SVH
`define NTT_DEFS_SVH

// Arithmetic
`define NTT_Q            8380417
`define NTT_COEF_W       24

// Memory geometry
`define NTT_LANES        4       // Coefficients per row
`define NTT_ROW_W        96
`define NTT_N            64      // Coefficients per polynomial
`define NTT_ROWS         16      // Rows per polynomial
`define NTT_ROW_ADDR_W   6       // Covers 48 rows

// Host bus
`define NTT_HOST_ADDR_W  8
`define NTT_HOST_DATA_W  32

// Host word map
`define NTT_BASE_A       0
`define NTT_BASE_B       64
`define NTT_BASE_C       128
`define NTT_ADDR_CTRL    192
`define NTT_ADDR_EN      193
`define NTT_ADDR_STATUS  194     // Last valid word

`endif
